// ==== verilog/video_pkg.sv ====
package video_pkg;

  ////////////////////////////////////////////////////////////
  // 800x600 raster, one pixel per clock
  ////////////////////////////////////////////////////////////

  // horizontal, in clocks
  localparam int H_VISIBLE = 800;
  localparam int H_FRONT   = 40;
  localparam int H_SYNC    = 128;
  localparam int H_BACK    = 88;
  localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;

  // vertical, in lines
  localparam int V_VISIBLE = 600;
  localparam int V_FRONT   = 1;
  localparam int V_SYNC    = 4;
  localparam int V_BACK    = 23;
  localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

  // both sync pulses are active high at this mode

  // raster position, 0..1055 and 0..627
  typedef logic [10:0] hcount_t;
  typedef logic [9:0]  vcount_t;

endpackage

// ==== verilog/frame_pkg.sv ====
package frame_pkg;

  ////////////////////////////////////////////////////////////
  // capture window and frame store
  ////////////////////////////////////////////////////////////

  // window origin inside the visible area
  localparam int H_OFFSET = 40;
  localparam int V_OFFSET = 0;

  localparam int WIN_WIDTH  = 32;
  localparam int WIN_HEIGHT = 24;
  localparam int FRAME_PIXELS = WIN_WIDTH * WIN_HEIGHT;

  // green, blue, red on the serial link
  localparam int BYTES_PER_PIXEL = 3;

  // raster order inside the window
  typedef logic [9:0] pix_addr_t;

  // red [23:16], green [15:8], blue [7:0]
  typedef logic [23:0] rgb24_t;
  // red [7:5], green [4:2], blue [1:0]
  typedef logic [7:0] rgb332_t;

  typedef logic [7:0] byte_t;
  // 0 green, 1 blue, 2 red
  typedef logic [1:0] comp_sel_t;

  typedef enum logic [1:0] {ST_IDLE, ST_CAPTURE, ST_SEND} fsm_state_t;

endpackage

// ==== verilog/vga_timing.sv ====
module vga_timing (
  input  logic               clk,
  input  logic               rst_n_i,
  output video_pkg::hcount_t hcount_o,
  output video_pkg::vcount_t vcount_o,
  output logic               hsync_o,
  output logic               vsync_o,
  output logic               blank_o
);

  video_pkg::hcount_t hcount_q;
  video_pkg::vcount_t vcount_q;
  logic               hsync_q;
  logic               vsync_q;
  logic               blank_q;
  logic               h_last;
  logic               v_last;

  // end of line / end of frame
  assign h_last = (hcount_q == video_pkg::hcount_t'(video_pkg::H_TOTAL - 1));
  assign v_last = (vcount_q == video_pkg::vcount_t'(video_pkg::V_TOTAL - 1));

  ////////////////////////////////////////////////////////////
  // raster counters
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      hcount_q <= '0;
      vcount_q <= '0;
    end else begin
      hcount_q <= h_last ? '0 : hcount_q + 1'b1;
      // line advances on the horizontal wrap
      if (h_last) begin
        vcount_q <= v_last ? '0 : vcount_q + 1'b1;
      end
    end
  end

  // sync and blank lag the counters by one clock
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      hsync_q <= 1'b0;
      vsync_q <= 1'b0;
      blank_q <= 1'b0;
    end else begin
      hsync_q <= (hcount_q >= video_pkg::H_VISIBLE + video_pkg::H_FRONT) &&
                 (hcount_q < video_pkg::H_VISIBLE + video_pkg::H_FRONT + video_pkg::H_SYNC);
      vsync_q <= (vcount_q >= video_pkg::V_VISIBLE + video_pkg::V_FRONT) &&
                 (vcount_q < video_pkg::V_VISIBLE + video_pkg::V_FRONT + video_pkg::V_SYNC);
      // outside the 800x600 area
      blank_q <= (hcount_q >= video_pkg::H_VISIBLE) || (vcount_q >= video_pkg::V_VISIBLE);
    end
  end

  assign hcount_o = hcount_q;
  assign vcount_o = vcount_q;
  assign hsync_o  = hsync_q;
  assign vsync_o  = vsync_q;
  assign blank_o  = blank_q;

endmodule

// ==== verilog/frame_capture.sv ====
module frame_capture (
  input  logic                clk,
  input  logic                rst_n_i,
  input  logic                arm_i,
  input  video_pkg::hcount_t  hcount_i,
  input  video_pkg::vcount_t  vcount_i,
  input  frame_pkg::rgb24_t   pixel_i,
  output logic                wr_en_o,
  output frame_pkg::pix_addr_t wr_addr_o,
  output frame_pkg::rgb332_t  wr_data_o,
  output logic                capture_done_o
);

  logic               active_q;
  logic               frame_top;
  logic               in_win;
  logic               last_pix;
  video_pkg::hcount_t col_off;
  video_pkg::vcount_t row_off;

  ////////////////////////////////////////////////////////////
  // window test and address
  ////////////////////////////////////////////////////////////

  // first raster position of a frame
  assign frame_top = (hcount_i == '0) && (vcount_i == '0);

  assign in_win = (hcount_i >= frame_pkg::H_OFFSET) &&
                  (hcount_i < frame_pkg::H_OFFSET + frame_pkg::WIN_WIDTH) &&
                  (vcount_i >= frame_pkg::V_OFFSET) &&
                  (vcount_i < frame_pkg::V_OFFSET + frame_pkg::WIN_HEIGHT);

  // offsets relative to the window origin
  assign col_off = hcount_i - video_pkg::hcount_t'(frame_pkg::H_OFFSET);
  assign row_off = vcount_i - video_pkg::vcount_t'(frame_pkg::V_OFFSET);

  // row * width + column
  assign wr_addr_o = frame_pkg::pix_addr_t'(row_off) *
                     frame_pkg::pix_addr_t'(frame_pkg::WIN_WIDTH) +
                     frame_pkg::pix_addr_t'(col_off);

  assign wr_en_o  = active_q && in_win && arm_i;
  assign last_pix = (wr_addr_o == frame_pkg::pix_addr_t'(frame_pkg::FRAME_PIXELS - 1));
  assign capture_done_o = wr_en_o && last_pix;

  // keep the top bits of each component
  assign wr_data_o = {pixel_i[23:21], pixel_i[15:13], pixel_i[7:6]};

  // active from frame top to the last window pixel
  always_ff @(posedge clk) begin
    if (!rst_n_i || !arm_i) begin
      active_q <= 1'b0;
    end else if (capture_done_o) begin
      active_q <= 1'b0;
    end else if (frame_top) begin
      active_q <= 1'b1;
    end
  end

endmodule

// ==== verilog/frame_bram.sv ====
module frame_bram (
  input  logic                 clk,
  input  logic                 wr_en_i,
  input  frame_pkg::pix_addr_t wr_addr_i,
  input  frame_pkg::rgb332_t   wr_data_i,
  input  frame_pkg::pix_addr_t rd_addr_i,
  output frame_pkg::rgb332_t   rd_data_o
);

  // one RGB332 pixel per window position
  frame_pkg::rgb332_t mem [0:frame_pkg::FRAME_PIXELS-1];
  frame_pkg::rgb332_t rd_data_q;

  // write port, fed by the capture side
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  // registered read, data valid the next cycle
  always_ff @(posedge clk) begin
    rd_data_q <= mem[rd_addr_i];
  end

  assign rd_data_o = rd_data_q;

endmodule

// ==== verilog/frame_sender.sv ====
module frame_sender (
  input  logic                 clk,
  input  logic                 rst_n_i,
  input  logic                 send_en_i,
  output frame_pkg::pix_addr_t rd_addr_o,
  input  frame_pkg::rgb332_t   rd_data_i,
  input  logic                 tx_busy_i,
  output logic                 tx_start_o,
  output frame_pkg::byte_t     tx_data_o,
  output logic                 send_done_o
);

  frame_pkg::pix_addr_t pix_cnt_q;
  frame_pkg::comp_sel_t comp_cnt_q;
  frame_pkg::rgb332_t   pix_q;
  logic                 rd_pend_q;
  logic                 have_pix_q;
  logic                 done_q;
  logic                 last_comp;
  logic                 last_pix;

  assign last_comp = (comp_cnt_q == frame_pkg::comp_sel_t'(frame_pkg::BYTES_PER_PIXEL - 1));
  assign last_pix  = (pix_cnt_q == frame_pkg::pix_addr_t'(frame_pkg::FRAME_PIXELS - 1));

  // one byte per idle UART cycle
  assign tx_start_o = have_pix_q && !tx_busy_i;
  assign rd_addr_o  = pix_cnt_q;

  ////////////////////////////////////////////////////////////
  // read, latch, then three bytes per pixel
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n_i || !send_en_i) begin
      pix_cnt_q  <= '0;
      comp_cnt_q <= '0;
      rd_pend_q  <= 1'b0;
      have_pix_q <= 1'b0;
      done_q     <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (!have_pix_q && !rd_pend_q && !done_q) begin
        // address already on the RAM, data next cycle
        rd_pend_q <= 1'b1;
      end else if (rd_pend_q) begin
        rd_pend_q  <= 1'b0;
        have_pix_q <= 1'b1;
      end else if (tx_start_o) begin
        if (last_comp) begin
          comp_cnt_q <= '0;
          have_pix_q <= 1'b0;
          if (last_pix) begin
            done_q <= 1'b1;
          end else begin
            pix_cnt_q <= pix_cnt_q + 1'b1;
          end
        end else begin
          comp_cnt_q <= comp_cnt_q + 1'b1;
        end
      end
    end
  end

  // pixel held for its three bytes
  always_ff @(posedge clk) begin
    if (rd_pend_q) begin
      pix_q <= rd_data_i;
    end
  end

  // left aligned, zero padded
  always_comb begin
    case (comp_cnt_q)
      2'd0:    tx_data_o = {pix_q[4:2], 5'b00000};
      2'd1:    tx_data_o = {pix_q[1:0], 6'b000000};
      default: tx_data_o = {pix_q[7:5], 5'b00000};
    endcase
  end

  assign send_done_o = done_q;

endmodule

// ==== verilog/uart_tx.sv ====
module uart_tx #(
  parameter int CLKS_PER_BIT = 347
) (
  input  logic             clk,
  input  logic             rst_n_i,
  input  logic             tx_start_i,
  input  frame_pkg::byte_t tx_data_i,
  output logic             tx_o,
  output logic             tx_busy_o
);

  localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);

  logic [CNT_W-1:0] clk_cnt_q;
  // bits already on the line, start = 0 .. stop = 9
  logic [3:0]       bit_idx_q;
  // data LSB first, then the stop bit
  logic [8:0]       shift_q;
  logic             tx_q;
  logic             busy_q;
  logic             bit_end;

  assign bit_end = (clk_cnt_q == CNT_W'(CLKS_PER_BIT - 1));

  ////////////////////////////////////////////////////////////
  // 8N1 shifter
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      clk_cnt_q <= '0;
      bit_idx_q <= '0;
      shift_q   <= '1;
      tx_q      <= 1'b1;
      busy_q    <= 1'b0;
    end else if (!busy_q) begin
      if (tx_start_i) begin
        // start bit goes out next cycle
        shift_q   <= {1'b1, tx_data_i};
        tx_q      <= 1'b0;
        busy_q    <= 1'b1;
        clk_cnt_q <= '0;
        bit_idx_q <= '0;
      end
    end else if (bit_end) begin
      clk_cnt_q <= '0;
      if (bit_idx_q == 4'd9) begin
        // stop bit done, line stays high
        busy_q <= 1'b0;
      end else begin
        tx_q      <= shift_q[0];
        shift_q   <= {1'b1, shift_q[8:1]};
        bit_idx_q <= bit_idx_q + 1'b1;
      end
    end else begin
      clk_cnt_q <= clk_cnt_q + 1'b1;
    end
  end

  assign tx_o      = tx_q;
  assign tx_busy_o = busy_q;

endmodule

// ==== verilog/capture_fsm.sv ====
module capture_fsm (
  input  logic clk,
  input  logic rst_n_i,
  input  logic start_i,
  input  logic capture_done_i,
  input  logic send_done_i,
  output logic arm_o,
  output logic send_en_o,
  output logic busy_o
);

  frame_pkg::fsm_state_t state_q;
  frame_pkg::fsm_state_t state_d;

  // idle -> capture -> send -> idle
  always_comb begin
    state_d = state_q;
    case (state_q)
      frame_pkg::ST_IDLE: begin
        // start only counts here
        if (start_i) state_d = frame_pkg::ST_CAPTURE;
      end
      frame_pkg::ST_CAPTURE: begin
        if (capture_done_i) state_d = frame_pkg::ST_SEND;
      end
      frame_pkg::ST_SEND: begin
        if (send_done_i) state_d = frame_pkg::ST_IDLE;
      end
      default: state_d = frame_pkg::ST_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n_i) begin
      state_q <= frame_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // levels decoded from the state
  assign arm_o     = (state_q == frame_pkg::ST_CAPTURE);
  assign send_en_o = (state_q == frame_pkg::ST_SEND);
  assign busy_o    = (state_q != frame_pkg::ST_IDLE);

endmodule

// ==== verilog/frame_dump_top.sv ====
module frame_dump_top #(
  parameter int CLKS_PER_BIT = 347
) (
  input  logic              clk,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  frame_pkg::rgb24_t pixel_i,
  output logic              hsync_o,
  output logic              vsync_o,
  output logic              blank_o,
  output logic              uart_tx_o,
  output logic              busy_o
);

  ////////////////////////////////////////////////////////////
  // raster and capture
  ////////////////////////////////////////////////////////////

  video_pkg::hcount_t   hcount;
  video_pkg::vcount_t   vcount;
  logic                 arm;
  logic                 wr_en;
  frame_pkg::pix_addr_t wr_addr;
  frame_pkg::rgb332_t   wr_data;
  logic                 capture_done;

  vga_timing u_vga_timing (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .hcount_o (hcount),
    .vcount_o (vcount),
    .hsync_o  (hsync_o),
    .vsync_o  (vsync_o),
    .blank_o  (blank_o)
  );

  frame_capture u_frame_capture (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .arm_i          (arm),
    .hcount_i       (hcount),
    .vcount_i       (vcount),
    .pixel_i        (pixel_i),
    .wr_en_o        (wr_en),
    .wr_addr_o      (wr_addr),
    .wr_data_o      (wr_data),
    .capture_done_o (capture_done)
  );

  // store and dump path
  frame_pkg::pix_addr_t rd_addr;
  frame_pkg::rgb332_t   rd_data;
  logic                 send_en;
  logic                 send_done;
  logic                 tx_start;
  frame_pkg::byte_t     tx_data;
  logic                 tx_busy;

  frame_bram u_frame_bram (
    .clk       (clk),
    .wr_en_i   (wr_en),
    .wr_addr_i (wr_addr),
    .wr_data_i (wr_data),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data)
  );

  frame_sender u_frame_sender (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .send_en_i   (send_en),
    .rd_addr_o   (rd_addr),
    .rd_data_i   (rd_data),
    .tx_busy_i   (tx_busy),
    .tx_start_o  (tx_start),
    .tx_data_o   (tx_data),
    .send_done_o (send_done)
  );

  uart_tx #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) u_uart_tx (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .tx_start_i (tx_start),
    .tx_data_i  (tx_data),
    .tx_o       (uart_tx_o),
    .tx_busy_o  (tx_busy)
  );

  // sequencing
  capture_fsm u_capture_fsm (
    .clk            (clk),
    .rst_n_i        (rst_n_i),
    .start_i        (start_i),
    .capture_done_i (capture_done),
    .send_done_i    (send_done),
    .arm_o          (arm),
    .send_en_o      (send_en),
    .busy_o         (busy_o)
  );

endmodule

// ==== bench/tb_frame_dump.sv ====
module tb_frame_dump;

  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////
  // raster, window and link figures
  ////////////////////////////////////////////////////////////
  localparam int CLKS_PER_BIT = 8;
  localparam int LINE_CLKS    = 1056;
  localparam int FRAME_LINES  = 628;
  localparam int VISIBLE_W    = 800;
  localparam int HSYNC_START  = 840;
  localparam int HSYNC_CLKS   = 128;
  localparam int VSYNC_LINES  = 4;
  localparam int WIN_X        = 40;
  localparam int WIN_Y        = 0;
  localparam int WIN_W        = 32;
  localparam int WIN_H        = 24;
  localparam int FRAME_PIX    = WIN_W * WIN_H;
  localparam int DUMP_BYTES   = FRAME_PIX * 3;
  // start, 8 data, stop
  localparam int BYTE_CLKS    = 10 * CLKS_PER_BIT;
  localparam longint WATCHDOG_CYCLES =
    5 * 663168 + 3 * DUMP_BYTES * BYTE_CLKS + 100000;

  logic                 clk;
  logic                 rst_n_i;
  logic                 start_i;
  frame_pkg::rgb24_t    pixel_i;
  logic                 hsync_o;
  logic                 vsync_o;
  logic                 blank_o;
  logic                 uart_tx_o;
  logic                 busy_o;

  // mirror of the raster position
  int                   h_pos;
  int                   v_pos;
  // pixels driven at window positions
  frame_pkg::rgb24_t    pix_table [0:FRAME_PIX-1];
  frame_pkg::byte_t     rx_q [$];
  int                   busy_falls;

  frame_dump_top #(
    .CLKS_PER_BIT (CLKS_PER_BIT)
  ) UUT (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .start_i   (start_i),
    .pixel_i   (pixel_i),
    .hsync_o   (hsync_o),
    .vsync_o   (vsync_o),
    .blank_o   (blank_o),
    .uart_tx_o (uart_tx_o),
    .busy_o    (busy_o)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #(WATCHDOG_CYCLES * 10);
    $display("watchdog expired before the tests completed");
    end_with_failure();
  end

  ////////////////////////////////////////////////////////////
  // failure path and compare tasks
  ////////////////////////////////////////////////////////////
  task automatic end_with_failure();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check_byte(input string test, input frame_pkg::byte_t exp,
                            input frame_pkg::byte_t act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %02h, actual %02h", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string test, input logic exp, input logic act);
    if (act !== exp) begin
      $display("CHECK FAILED %s: expected %b, actual %b", test, exp, act);
      end_with_failure();
    end
  endtask

  task automatic check_count(input string test, input int exp, input int act);
    if (act != exp) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", test, exp, act);
      end_with_failure();
    end
  endtask

  // component k of pixel: 0 green, 1 blue, 2 red, top bits kept
  function automatic frame_pkg::byte_t expected_byte(input frame_pkg::rgb24_t pix,
                                                     input int k);
    if (k == 0) begin
      return pix[15:8] & 8'he0;
    end else if (k == 1) begin
      return pix[7:0] & 8'hc0;
    end
    return pix[23:16] & 8'he0;
  endfunction

  ////////////////////////////////////////////////////////////
  // pixel source and monitors
  ////////////////////////////////////////////////////////////

  // raster follows the counters, (0,0) in the first cycle out of reset
  initial begin
    h_pos = 0;
    v_pos = 0;
    forever begin
      @(posedge clk);
      if (!rst_n_i) begin
        h_pos <= 0;
        v_pos <= 0;
      end else if (h_pos == LINE_CLKS - 1) begin
        h_pos <= 0;
        v_pos <= (v_pos == FRAME_LINES - 1) ? 0 : v_pos + 1;
      end else begin
        h_pos <= h_pos + 1;
      end
    end
  end

  // table pixel inside the window, filler elsewhere
  initial begin
    pixel_i = '0;
    forever begin
      @(negedge clk);
      if (h_pos >= WIN_X && h_pos < WIN_X + WIN_W && v_pos >= WIN_Y && v_pos < WIN_Y + WIN_H) begin
        pixel_i <= pix_table[(v_pos - WIN_Y) * WIN_W + h_pos - WIN_X];
      end else begin
        pixel_i <= {8'(h_pos), 8'(v_pos), 8'h5a};
      end
    end
  end

  // 8N1 receiver, samples near mid bit on falling edges
  initial begin : uart_decoder
    frame_pkg::byte_t data;
    forever begin
      @(negedge clk);
      if (rst_n_i === 1'b1 && uart_tx_o === 1'b0) begin
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge clk);
        check_bit("uart start bit", 1'b0, uart_tx_o);
        for (int i = 0; i < 8; i++) begin
          repeat (CLKS_PER_BIT) @(negedge clk);
          data[i] = uart_tx_o;
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_bit("uart stop bit", 1'b1, uart_tx_o);
        rx_q.push_back(data);
      end
    end
  end

  // falling edges of busy
  initial begin : busy_monitor
    logic busy_prev;
    busy_prev = 1'b0;
    busy_falls = 0;
    forever begin
      @(negedge clk);
      if (busy_prev === 1'b1 && busy_o === 1'b0) begin
        busy_falls++;
      end
      busy_prev = busy_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // directed tests
  ////////////////////////////////////////////////////////////
  task automatic reset_dut();
    rst_n_i = 1'b0;
    repeat (10) @(negedge clk);
    check_bit("reset uart_tx_o", 1'b1, uart_tx_o);
    check_bit("reset busy_o", 1'b0, busy_o);
    check_bit("reset hsync_o", 1'b0, hsync_o);
    check_bit("reset vsync_o", 1'b0, vsync_o);
    rst_n_i <= 1'b1;
  endtask

  task automatic check_sync_timing();
    int cyc;
    // hsync: width, start position, period
    while (hsync_o) @(negedge clk);
    while (!hsync_o) @(negedge clk);
    // registered, so the counters are one past the start
    check_count("hsync start position", HSYNC_START + 1, h_pos);
    cyc = 0;
    while (hsync_o) begin
      @(negedge clk);
      cyc++;
    end
    check_count("hsync width", HSYNC_CLKS, cyc);
    while (!hsync_o) begin
      @(negedge clk);
      cyc++;
    end
    check_count("hsync period", LINE_CLKS, cyc);
    // vsync
    while (vsync_o) @(negedge clk);
    while (!vsync_o) @(negedge clk);
    cyc = 0;
    while (vsync_o) begin
      @(negedge clk);
      cyc++;
    end
    check_count("vsync width", VSYNC_LINES * LINE_CLKS, cyc);
    while (!vsync_o) begin
      @(negedge clk);
      cyc++;
    end
    check_count("vsync period", FRAME_LINES * LINE_CLKS, cyc);
    // one visible run of blank low
    while (!blank_o) @(negedge clk);
    while (blank_o) @(negedge clk);
    cyc = 0;
    while (!blank_o) begin
      @(negedge clk);
      cyc++;
    end
    check_count("blank visible run", VISIBLE_W, cyc);
  endtask

  task automatic fill_pattern(input frame_pkg::byte_t seed);
    for (int p = 0; p < FRAME_PIX; p++) begin
      pix_table[p] = {8'(p * 7) ^ seed, 8'(p >> 2) + seed, ~8'(p)};
    end
  endtask

  task automatic fill_random();
    for (int p = 0; p < FRAME_PIX; p++) begin
      pix_table[p] = 24'($urandom);
    end
  endtask

  task automatic pulse_start();
    @(negedge clk);
    start_i <= 1'b1;
    @(negedge clk);
    start_i <= 1'b0;
  endtask

  // one capture and dump, optionally poked again mid dump
  task automatic dump_and_check(input string name, input bit poke_mid);
    int falls_before;
    int wait_cyc;
    rx_q.delete();
    falls_before = busy_falls;
    pulse_start();
    while (!busy_o) @(negedge clk);
    if (poke_mid) begin
      while (rx_q.size() < 100) @(negedge clk);
      check_bit({name, " busy mid dump"}, 1'b1, busy_o);
      pulse_start();
    end
    while (busy_o) @(negedge clk);
    // last byte still on the line
    wait_cyc = 0;
    while (rx_q.size() < DUMP_BYTES && wait_cyc < 2 * BYTE_CLKS) begin
      @(negedge clk);
      wait_cyc++;
    end
    check_count({name, " byte count"}, DUMP_BYTES, rx_q.size());
    for (int p = 0; p < FRAME_PIX; p++) begin
      for (int k = 0; k < 3; k++) begin
        check_byte($sformatf("%s byte %0d", name, 3 * p + k),
                   expected_byte(pix_table[p], k), rx_q[3 * p + k]);
      end
    end
    // line stays quiet afterwards
    repeat (4 * BYTE_CLKS) @(negedge clk);
    check_count({name, " trailing bytes"}, DUMP_BYTES, rx_q.size());
    check_count({name, " busy falls"}, 1, busy_falls - falls_before);
  endtask

  initial begin : main
    void'($urandom(32'h9b09));
    rst_n_i = 1'b0;
    start_i = 1'b0;
    fill_pattern(8'h00);
    reset_dut();
    check_sync_timing();
    fill_pattern(8'h3c);
    dump_and_check("dump pattern", 1'b0);
    fill_pattern(8'hc5);
    dump_and_check("start while busy", 1'b1);
    fill_random();
    dump_and_check("random overwrite", 1'b0);
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== filelist.f ====
verilog/video_pkg.sv
verilog/frame_pkg.sv
verilog/vga_timing.sv
verilog/frame_capture.sv
verilog/frame_bram.sv
verilog/frame_sender.sv
verilog/uart_tx.sv
verilog/capture_fsm.sv
verilog/frame_dump_top.sv
bench/tb_frame_dump.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the frame dump testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module tb_frame_dump \
  -f filelist.f -o tb_frame_dump
./obj_dir/tb_frame_dump
